//--- Bender.yml
package:
  name: residu_filter

sources:
  - verilog/residuPkg.sv
  - verilog/coefBank.sv
  - verilog/sampleHistory.sv
  - verilog/macStage.sv
  - verilog/roundStage.sv
  - verilog/residuFilter.sv
  - target: simulation
    files:
      - sim/residuFilterTb.sv

//--- build.f
verilog/residuPkg.sv
verilog/coefBank.sv
verilog/sampleHistory.sv
verilog/macStage.sv
verilog/roundStage.sv
verilog/residuFilter.sv
sim/residuFilterTb.sv

//--- sim/residuFilterTb.sv
`timescale 1ns/1ps

module residuFilterTb;
	import residuPkg::*;

	localparam int waitLimit = 2000;

	logic clk = 1'b0;
	logic reset;
	logic coefWrite;
	tapIndex_t coefAddr;
	sample_t coefData;
	logic sampleReq;
	sample_t sampleData;
	logic sampleAck;
	logic resultReq;
	sample_t resultData;
	logic resultAck;

	logic [31:0] lfsr = 32'he06c;
	sample_t modelCoef [tapCount];
	sample_t modelHist [tapCount];
	sample_t expected [$];
	sample_t stimulus [$];
	sample_t received [$];
	int accepted;
	int consumed;
	int maxInFlight;

	residuFilter residuFilter_i (
		.clk(clk),
		.reset(reset),
		.coefWrite(coefWrite),
		.coefAddr(coefAddr),
		.coefData(coefData),
		.sampleReq(sampleReq),
		.sampleData(sampleData),
		.sampleAck(sampleAck),
		.resultReq(resultReq),
		.resultData(resultData),
		.resultAck(resultAck)
	);

	always #20 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Random bits
	//////////////////////////////////////////////////////////////////////

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic drawBits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			value[i] = lfsr[0];
			lfsr = lfsrNext(lfsr);
		end
	endtask

	// Mode 0 any value, 1 near positive full scale, 2 near negative full scale
	task automatic randomSample(input int mode, output sample_t s);
		logic [31:0] bits;
		if (mode == 0)
		begin
			drawBits(16, bits);
			s = bits[15:0];
		end
		else
		begin
			drawBits(6, bits);
			s = (mode == 1) ? 16'sh7fff - bits[5:0] : 16'sh8000 + bits[5:0];
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////
	function automatic longint clampWord(longint v);
		if (v > longint'(32'sh7fff_ffff))
			return longint'(32'sh7fff_ffff);
		if (v < longint'(32'sh8000_0000))
			return longint'(32'sh8000_0000);
		return v;
	endfunction

	// Products and partial sums saturate one by one from tap 0
	function automatic sample_t modelOutput();
		longint sum;
		longint prod;
		sum = 0;
		for (int j = 0; j < tapCount; j++)
		begin
			prod = clampWord(2 * longint'(modelCoef[j]) * longint'(modelHist[j]));
			sum = clampWord(sum + prod);
		end
		sum = clampWord(sum * 8);
		sum = clampWord(sum + 32768);
		return sample_t'(sum >>> 16);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checking and waiting
	//////////////////////////////////////////////////////////////////////
	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic compareValue(input string name, input logic signed [63:0] actual,
		input logic signed [63:0] expectedValue);
		if (actual !== expectedValue)
		begin
			$display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, actual,
				expectedValue);
			abortRun("Stopped at the first mismatch");
		end
	endtask

	task automatic waitSampleAck(input logic level);
		int cycles;
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
			if (cycles > waitLimit)
				abortRun("Timed out waiting for sampleAck to change");
		end
		while (sampleAck !== level);
	endtask

	task automatic waitResultReq(input logic level);
		int cycles;
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
			if (cycles > waitLimit)
				abortRun("Timed out waiting for resultReq to change");
		end
		while (resultReq !== level);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Drivers
	//////////////////////////////////////////////////////////////////////
	task automatic applyReset();
		reset <= 1'b1;
		sampleReq <= 1'b0;
		resultAck <= 1'b0;
		coefWrite <= 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		for (int j = 0; j < tapCount; j++)
		begin
			modelCoef[j] = '0;
			modelHist[j] = '0;
		end
		expected.delete();
		accepted = 0;
		consumed = 0;
	endtask

	task automatic loadCoefs(input int mode);
		sample_t c;
		for (int j = 0; j < tapCount; j++)
		begin
			randomSample(mode, c);
			@(posedge clk);
			coefWrite <= 1'b1;
			coefAddr <= tapIndex_t'(j);
			coefData <= c;
			modelCoef[j] = c;
		end
		@(posedge clk);
		coefWrite <= 1'b0;
	endtask

	task automatic queueSamples(input int count, input int mode);
		sample_t s;
		for (int i = 0; i < count; i++)
		begin
			randomSample(mode, s);
			stimulus.push_back(s);
		end
	endtask

	// Model history advances when the DUT takes a sample
	task automatic sendSamples();
		sample_t s;
		while (stimulus.size() > 0)
		begin
			s = stimulus.pop_front();
			@(posedge clk);
			sampleReq <= 1'b1;
			sampleData <= s;
			waitSampleAck(1'b1);
			sampleReq <= 1'b0;
			for (int j = tapCount - 1; j > 0; j--)
				modelHist[j] = modelHist[j - 1];
			modelHist[0] = s;
			expected.push_back(modelOutput());
			accepted++;
			if (accepted - consumed > maxInFlight)
				maxInFlight = accepted - consumed;
			if (accepted - consumed > 3)
				abortRun("More than three samples were accepted into the pipeline");
			waitSampleAck(1'b0);
		end
	endtask

	// Ack held back by up to 2^delayBits - 1 cycles
	task automatic receiveResults(input int count, input int delayBits);
		logic [31:0] delay;
		for (int i = 0; i < count; i++)
		begin
			waitResultReq(1'b1);
			drawBits(delayBits, delay);
			repeat (delay) @(posedge clk);
			if (expected.size() == 0)
				abortRun("A result arrived with no sample outstanding");
			compareValue("resultData", resultData, expected.pop_front());
			received.push_back(resultData);
			resultAck <= 1'b1;
			waitResultReq(1'b0);
			consumed++;
			resultAck <= 1'b0;
		end
	endtask

	task automatic runStream(input int delayBits);
		int count;
		count = stimulus.size();
		received.delete();
		fork
			sendSamples();
			receiveResults(count, delayBits);
		join
		// Nothing extra may follow
		repeat (30) @(posedge clk);
		compareValue("resultReq", resultReq, 0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		longint impulseRef;
		int sawHigh;
		int sawLow;
		reset = 1'b1;
		coefWrite = 1'b0;
		coefAddr = '0;
		coefData = '0;
		sampleReq = 1'b0;
		sampleData = '0;
		resultAck = 1'b0;
		maxInFlight = 0;
		applyReset();

		// Bank still cleared
		queueSamples(20, 0);
		runStream(0);
		foreach (received[i])
			compareValue("resultData after reset", received[i], 0);

		// Zeros flush the history, then a single 4096
		loadCoefs(0);
		repeat (tapCount - 1) stimulus.push_back('0);
		stimulus.push_back(16'sd4096);
		repeat (tapCount - 1) stimulus.push_back('0);
		runStream(0);
		for (int j = 0; j < tapCount; j++)
		begin
			impulseRef = clampWord(clampWord(2 * 4096 * longint'(modelCoef[j])) * 8);
			impulseRef = clampWord(impulseRef + 32768) >>> 16;
			compareValue("impulse resultData", received[tapCount - 1 + j], impulseRef);
		end

		loadCoefs(0);
		queueSamples(200, 0);
		runStream(0);

		// Full scale both ways
		loadCoefs(1);
		queueSamples(20, 1);
		queueSamples(20, 2);
		runStream(0);
		sawHigh = 0;
		sawLow = 0;
		foreach (received[i])
		begin
			if (received[i] == 16'sh7fff)
				sawHigh = 1;
			if (received[i] == 16'sh8000)
				sawLow = 1;
		end
		compareValue("positive saturated result seen", sawHigh, 1);
		compareValue("negative saturated result seen", sawLow, 1);

		// Slow consumer fills all three stages
		loadCoefs(0);
		maxInFlight = 0;
		queueSamples(60, 0);
		runStream(6);
		compareValue("samples in flight", maxInFlight, 3);

		// Reset with samples still in the pipeline
		queueSamples(3, 0);
		sendSamples();
		repeat (5) @(posedge clk);
		applyReset();
		loadCoefs(0);
		queueSamples(30, 0);
		runStream(3);

		$display("Everything OK");
		$finish;
	end

endmodule

//--- verilog/coefBank.sv
`timescale 1ns/1ps

module coefBank (
	input logic clk,
	input logic reset,
	input logic coefWrite,
	input residuPkg::tapIndex_t coefAddr,
	input residuPkg::sample_t coefData,
	input residuPkg::tapIndex_t tapSel,
	output residuPkg::sample_t coefOut
);
	import residuPkg::*;

	sample_t coefs [tapCount];

	// One coefficient per write, all cleared at reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < tapCount; i++)
				coefs[i] <= '0;
		end
		else if (coefWrite && coefAddr < tapCount)
			coefs[coefAddr] <= coefData;
	end

	// Combinational read for the MAC stage
	assign coefOut = (tapSel < tapCount) ? coefs[tapSel] : '0;

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Writes outside the tap range would be silently dropped
	coefAddrInRange: assert property (
		@(posedge clk) disable iff (reset)
		coefWrite |-> coefAddr < tapCount
	)
	else
		$error("coefBank write to address %0d", coefAddr);

endmodule

//--- verilog/macStage.sv
`timescale 1ns/1ps

module macStage (
	input logic clk,
	input logic reset,
	input logic windowReq,
	input residuPkg::sampleWindow_t window,
	output logic windowAck,
	output residuPkg::tapIndex_t tapSel,
	input residuPkg::sample_t coefOut,
	output logic accReq,
	output residuPkg::accWord_u acc,
	input logic accAck
);
	import residuPkg::*;

	sampleWindow_t capWindow;
	sample_t tapSample;
	logic accumulating;
	logic idle;
	logic lastTap;
	logic capture;

	// Idle only after window and accumulator handshakes are both closed
	assign idle = !accumulating && !accReq && !accAck && !windowAck;
	assign capture = windowReq && idle;
	assign lastTap = tapSel == tapIndex_t'(tapCount - 1);
	assign tapSample = capWindow[tapSel];

	//////////////////////////////////////////////////////////////////////
	// Controller
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			windowAck <= 1'b0;
			accumulating <= 1'b0;
			tapSel <= '0;
			accReq <= 1'b0;
		end
		else
		begin
			// Window side
			if (capture)
			begin
				windowAck <= 1'b1;
				accumulating <= 1'b1;
				tapSel <= '0;
			end
			else if (windowAck && !windowReq)
				windowAck <= 1'b0;

			// One tap per cycle, hand off after the last
			if (accumulating)
			begin
				if (lastTap)
				begin
					accumulating <= 1'b0;
					accReq <= 1'b1;
				end
				else
					tapSel <= tapSel + 1'b1;
			end

			if (accReq && accAck)
				accReq <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (capture)
			capWindow <= window;
		if (accumulating)
		begin
			// Tap 0 starts a fresh sum
			if (tapSel == '0)
				acc.word <= lMult(coefOut, tapSample);
			else
				acc.word <= lMac(acc.word, coefOut, tapSample);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////
	tapInRange: assert property (
		@(posedge clk) disable iff (reset)
		accumulating |-> tapSel < tapCount
	)
	else
		$error("macStage tap index %0d out of range", tapSel);

endmodule

//--- verilog/residuFilter.sv
`timescale 1ns/1ps

module residuFilter (
	input logic clk,
	input logic reset,
	input logic coefWrite,
	input residuPkg::tapIndex_t coefAddr,
	input residuPkg::sample_t coefData,
	input logic sampleReq,
	input residuPkg::sample_t sampleData,
	output logic sampleAck,
	output logic resultReq,
	output residuPkg::sample_t resultData,
	input logic resultAck
);
	import residuPkg::*;

	// History to MAC
	logic windowReq;
	logic windowAck;
	sampleWindow_t window;

	// MAC to round
	logic accReq;
	logic accAck;
	accWord_u acc;

	// Coefficient read path
	tapIndex_t tapSel;
	sample_t coefOut;

	coefBank coefBank_i (
		.clk(clk),
		.reset(reset),
		.coefWrite(coefWrite),
		.coefAddr(coefAddr),
		.coefData(coefData),
		.tapSel(tapSel),
		.coefOut(coefOut)
	);

	sampleHistory sampleHistory_i (
		.clk(clk),
		.reset(reset),
		.sampleReq(sampleReq),
		.sampleData(sampleData),
		.sampleAck(sampleAck),
		.windowReq(windowReq),
		.window(window),
		.windowAck(windowAck)
	);

	macStage macStage_i (
		.clk(clk),
		.reset(reset),
		.windowReq(windowReq),
		.window(window),
		.windowAck(windowAck),
		.tapSel(tapSel),
		.coefOut(coefOut),
		.accReq(accReq),
		.acc(acc),
		.accAck(accAck)
	);

	roundStage roundStage_i (
		.clk(clk),
		.reset(reset),
		.accReq(accReq),
		.acc(acc),
		.accAck(accAck),
		.resultReq(resultReq),
		.resultData(resultData),
		.resultAck(resultAck)
	);

endmodule

//--- verilog/residuPkg.sv
package residuPkg;

	//////////////////////////////////////////////////////////////////////
	// Filter constants
	//////////////////////////////////////////////////////////////////////
	localparam int unsigned tapCount = 11;
	localparam int unsigned sampleWidth = 16;
	localparam int unsigned accWidth = 32;
	localparam int unsigned shiftAmount = 3;
	localparam logic signed [accWidth-1:0] roundBias = 32'sh0000_8000;

	// Saturation limits of the 32-bit word
	localparam logic signed [accWidth-1:0] maxWord = 32'sh7fff_ffff;
	localparam logic signed [accWidth-1:0] minWord = 32'sh8000_0000;

	typedef logic [3:0] tapIndex_t;
	typedef logic signed [sampleWidth-1:0] sample_t;

	// Element j holds x[n-j]
	typedef sample_t [tapCount-1:0] sampleWindow_t;

	// Accumulator seen whole, or split for round
	typedef union packed {
		logic signed [accWidth-1:0] word;
		struct packed {
			logic [sampleWidth-1:0] high;
			logic [sampleWidth-1:0] low;
		} halves;
	} accWord_u;

	//////////////////////////////////////////////////////////////////////
	// Saturating basic operations
	//////////////////////////////////////////////////////////////////////
	function automatic logic signed [accWidth-1:0] lAdd(logic signed [accWidth-1:0] a,
		logic signed [accWidth-1:0] b);
		logic signed [accWidth:0] sum;
		sum = {a[accWidth-1], a} + {b[accWidth-1], b};
		// Carry into the guard bit disagrees with the sign on overflow
		if (sum[accWidth] != sum[accWidth-1])
			return sum[accWidth] ? minWord : maxWord;
		return sum[accWidth-1:0];
	endfunction

	function automatic logic signed [accWidth-1:0] lMult(sample_t a, sample_t b);
		logic signed [accWidth-1:0] prod;
		prod = a * b;
		// Only -32768 squared overflows the doubling
		if (prod == 32'sh4000_0000)
			return maxWord;
		return prod <<< 1;
	endfunction

	function automatic logic signed [accWidth-1:0] lMac(logic signed [accWidth-1:0] acc,
		sample_t a, sample_t b);
		return lAdd(acc, lMult(a, b));
	endfunction

	function automatic logic signed [accWidth-1:0] lShl(logic signed [accWidth-1:0] v,
		int unsigned n);
		logic signed [accWidth-1:0] shifted;
		shifted = v <<< n;
		// Bits lost off the top show up when shifting back
		if ((shifted >>> n) != v)
			return v[accWidth-1] ? minWord : maxWord;
		return shifted;
	endfunction

	function automatic sample_t roundHigh(accWord_u v);
		accWord_u biased;
		biased.word = lAdd(v.word, roundBias);
		return sample_t'(biased.halves.high);
	endfunction

endpackage

//--- verilog/roundStage.sv
`timescale 1ns/1ps

module roundStage (
	input logic clk,
	input logic reset,
	input logic accReq,
	input residuPkg::accWord_u acc,
	output logic accAck,
	output logic resultReq,
	output residuPkg::sample_t resultData,
	input logic resultAck
);
	import residuPkg::*;

	accWord_u shifted;
	logic held;
	logic draining;
	logic capture;

	assign shifted.word = lShl(acc.word, shiftAmount);
	// New word only once the previous result has fully left
	assign capture = accReq && !accAck && !held && !resultReq && !draining;

	//////////////////////////////////////////////////////////////////////
	// Handshakes
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			accAck <= 1'b0;
			held <= 1'b0;
			resultReq <= 1'b0;
			draining <= 1'b0;
		end
		else
		begin
			if (capture)
			begin
				accAck <= 1'b1;
				held <= 1'b1;
			end
			else if (accAck && !accReq)
				accAck <= 1'b0;

			// Output side, req one cycle after capture
			if (held && !resultAck)
			begin
				held <= 1'b0;
				resultReq <= 1'b1;
			end
			else if (resultReq && resultAck)
			begin
				resultReq <= 1'b0;
				draining <= 1'b1;
			end
			else if (draining && !resultAck)
				draining <= 1'b0;
		end
	end

	// Result computed on capture and held through the output handshake
	always_ff @(posedge clk)
	begin
		if (capture)
			resultData <= roundHigh(shifted);
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////
	reqAfterAckLow: assert property (
		@(posedge clk) disable iff (reset)
		$rose(resultReq) |-> $past(!resultAck)
	)
	else
		$error("roundStage raised resultReq with resultAck still high");

endmodule

//--- verilog/sampleHistory.sv
`timescale 1ns/1ps

module sampleHistory (
	input logic clk,
	input logic reset,
	input logic sampleReq,
	input residuPkg::sample_t sampleData,
	output logic sampleAck,
	output logic windowReq,
	output residuPkg::sampleWindow_t window,
	input logic windowAck
);
	import residuPkg::*;

	logic windowFree;
	logic takeSample;

	// Window output free once both phases of the last transfer closed
	assign windowFree = !windowReq && !windowAck;
	assign takeSample = sampleReq && !sampleAck && windowFree;

	//////////////////////////////////////////////////////////////////////
	// Input handshake
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
			sampleAck <= 1'b0;
		else if (takeSample)
			sampleAck <= 1'b1;
		else if (sampleAck && !sampleReq)
			sampleAck <= 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Delay line and window handshake
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			window <= '0;
			windowReq <= 1'b0;
		end
		else
		begin
			if (takeSample)
			begin
				// Newest sample lands in element 0
				window <= {window[tapCount-2:0], sampleData};
				windowReq <= 1'b1;
			end
			else if (windowReq && windowAck)
				windowReq <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// MAC stage samples the window on its ack, so it must not move before
	windowHeld: assert property (
		@(posedge clk) disable iff (reset)
		windowReq && !windowAck |=> $stable(window)
	)
	else
		$error("sampleHistory window changed before windowAck");

endmodule
